// File: hdl/fpadd_pkg.sv
// Float field types, operation codes and stage payloads shared by every stage of the adder
package fpadd_pkg;

	typedef logic [7:0] float_exp_t;
	typedef logic [22:0] float_mant_t;

	typedef struct packed {
		logic        sign;
		float_exp_t  exp;
		float_mant_t mant;
	} float_t;

	// Implicit one, stored mantissa, then guard, round and sticky positions
	typedef logic [26:0] mant_ext_t;

	localparam float_exp_t FLOAT_EXP_BIAS = 8'd127;
	localparam float_exp_t FLOAT_EXP_MAX = 8'd255;
	localparam float_t FLOAT_NAN = 32'h7f800001;

	typedef enum logic [1:0] {
		OP_ADD  = 2'd0,
		OP_SUB  = 2'd1,
		OP_ITOF = 2'd2
	} fp_op_e;

	localparam int MAX_SHIFT = 32;
	typedef logic [5:0] shift_t;

	// Bit 30 of a converted integer lands on the implicit one
	localparam float_exp_t INT_EXP_REF = FLOAT_EXP_BIAS + 8'd30;

	typedef struct packed {
		logic exp_zero;
		logic exp_max;
		logic mant_zero;
	} float_class_t;

	function automatic float_class_t classify_float(float_t f);
		float_class_t c;
		c.exp_zero = (f.exp == '0);
		c.exp_max = (f.exp == FLOAT_EXP_MAX);
		c.mant_zero = (f.mant == '0);
		return c;
	endfunction

	// NaN and infinity share one slow path
	function automatic logic is_special(float_class_t c);
		return c.exp_max;
	endfunction

	typedef struct packed {
		fp_op_e       op;
		logic         slow;
		logic         zero;
		float_t       max;
		float_t       min;
		float_class_t max_class;
		float_class_t min_class;
		shift_t       shift;
	} align_out_t;

	typedef struct packed {
		fp_op_e    op;
		logic      slow;
		logic      zero;
		float_t    max;
		mant_ext_t max_mant;
		mant_ext_t min_mant;
		logic      min_sign;
		logic      sticky;
		logic      int_sign;
	} addsub_in_t;

	typedef struct packed {
		fp_op_e      op;
		logic        slow;
		logic        zero;
		float_exp_t  exp;
		logic        sign;
		logic [31:0] sum;
		logic        sticky;
	} addsub_out_t;

	typedef struct packed {
		addsub_out_t hold;
		shift_t      shift;
	} clz_out_t;

	typedef struct packed {
		fp_op_e op;
		logic   slow;
		logic   zero;
		float_t val;
		logic   guard;
		logic   round;
		logic   sticky;
		logic   overflow;
	} norm_out_t;

	typedef norm_out_t round_in_t;

endpackage

// File: hdl/fpadd_align.sv
// First three adder stages that order the operands and right-align the smaller mantissa
`timescale 1ns/10ps

module fpadd_align (
	input  logic                   clk,
	input  logic                   in_valid,
	input  fpadd_pkg::fp_op_e      op,
	input  fpadd_pkg::float_t      a,
	input  fpadd_pkg::float_t      b,
	output fpadd_pkg::addsub_in_t  out
);
	import fpadd_pkg::*;

	localparam mant_ext_t MANT_ONES = '1;

	float_t b_eff;
	float_class_t a_cls;
	float_class_t b_cls;
	logic b_first;
	align_out_t s1;
	align_out_t s2;
	float_exp_t exp_diff;
	mant_ext_t min_full;

	// Zero exponent reads as zero, so the implicit one is dropped too
	function automatic mant_ext_t prepare_mant(float_t f, float_class_t c);
		if (c.exp_zero)
			return '0;
		return {1'b1, f.mant, 3'b000};
	endfunction

	always_comb begin
		b_eff = b;
		if (op == OP_SUB)
			b_eff.sign = ~b.sign;
	end

	assign a_cls = classify_float(a);
	assign b_cls = classify_float(b);

	// Magnitude first, then the positive operand wins a tie
	assign b_first = (op != OP_ITOF) &&
		({b_eff.exp, b_eff.mant, ~b_eff.sign} > {a.exp, a.mant, ~a.sign});

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1.op <= op;
			s1.max <= b_first ? b_eff : a;
			s1.min <= b_first ? a : b_eff;
			s1.max_class <= b_first ? b_cls : a_cls;
			s1.min_class <= b_first ? a_cls : b_cls;
			s1.shift <= '0;
			s1.slow <= (op != OP_ITOF) && (is_special(a_cls) || is_special(b_cls));
			if (op == OP_ITOF)
				s1.zero <= a_cls.exp_zero & a_cls.mant_zero & ~a.sign;
			else
				s1.zero <= a_cls.exp_zero & b_cls.exp_zero;
		end
	end

	assign exp_diff = s1.max.exp - s1.min.exp;

	always_ff @(posedge clk) begin
		s2 <= s1;
		if (exp_diff > float_exp_t'(MAX_SHIFT))
			s2.shift <= shift_t'(MAX_SHIFT);
		else
			s2.shift <= exp_diff[5:0];
	end

	assign min_full = prepare_mant(s2.min, s2.min_class);

	always_ff @(posedge clk) begin
		out.op <= s2.op;
		out.slow <= s2.slow;
		out.zero <= s2.zero;
		out.max <= s2.max;
		out.max_mant <= prepare_mant(s2.max, s2.max_class);
		out.min_mant <= min_full >> s2.shift;
		out.min_sign <= s2.min.sign;
		out.sticky <= |(min_full & ~(MANT_ONES << s2.shift));
		out.int_sign <= s2.max.sign;

		// Integer conversion works on the magnitude
		if (s2.op == OP_ITOF && s2.max.sign)
			out.max <= float_t'(-s2.max);
	end

endmodule

// File: hdl/fpadd_mant_add.sv
// Adder stage that adds or subtracts the aligned mantissas or loads an integer magnitude
`timescale 1ns/10ps

module fpadd_mant_add (
	input  logic                   clk,
	input  fpadd_pkg::addsub_in_t  in,
	output fpadd_pkg::addsub_out_t out
);
	import fpadd_pkg::*;

	logic [31:0] max_word;
	logic [31:0] min_word;

	// Top bit stays clear to catch the carry of an addition
	assign max_word = {1'b0, in.max_mant, 4'b0000};

	// Lost alignment bits are jammed into the lowest position
	assign min_word = {1'b0, in.min_mant | mant_ext_t'(in.sticky), 4'b0000};

	always_ff @(posedge clk) begin
		out.op <= in.op;
		out.slow <= in.slow;
		out.zero <= in.zero;

		if (in.op == OP_ITOF) begin
			out.exp <= INT_EXP_REF;
			out.sign <= in.int_sign;
			out.sum <= in.max;
			out.sticky <= 1'b0;
		end else begin
			out.exp <= in.max.exp;
			out.sign <= in.max.sign;
			out.sticky <= in.sticky;

			// The effective operation comes from the two signs
			if (in.max.sign ^ in.min_sign)
				out.sum <= max_word - min_word;
			else
				out.sum <= max_word + min_word;
		end
	end

endmodule

// File: hdl/fpadd_clz.sv
// Pipelined leading-zero count of the mantissa sum with the payload delayed alongside
`timescale 1ns/10ps

module fpadd_clz #(
	parameter int CLZ_STAGES = 4
) (
	input  logic                   clk,
	input  fpadd_pkg::addsub_out_t in,
	output fpadd_pkg::clz_out_t    out
);
	import fpadd_pkg::*;

	// Pair merges from single bits up to the whole word
	localparam int LEVELS = 5;

	typedef shift_t [31:0] cnt_vec_t;

	cnt_vec_t leaf;
	cnt_vec_t cnt [CLZ_STAGES];
	addsub_out_t hold [CLZ_STAGES];

	function automatic int level_bound(int s);
		return (s * LEVELS) / CLZ_STAGES;
	endfunction

	// Entry 0 is the most significant group, merged in place
	function automatic cnt_vec_t merge_levels(cnt_vec_t c, int first, int last);
		cnt_vec_t r;
		int w;
		r = c;
		for (int l = first; l < last; l++) begin
			w = 1 << l;
			for (int g = 0; g < (16 >> l); g++) begin
				if (r[2 * g] == shift_t'(w))
					r[g] = shift_t'(w) + r[2 * g + 1];
				else
					r[g] = r[2 * g];
			end
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < 32; i++)
			leaf[i] = {5'b00000, ~in.sum[31 - i]};
	end

	always_ff @(posedge clk) begin
		cnt[0] <= merge_levels(leaf, 0, level_bound(1));
		hold[0] <= in;
		for (int s = 1; s < CLZ_STAGES; s++) begin
			cnt[s] <= merge_levels(cnt[s - 1], level_bound(s), level_bound(s + 1));
			hold[s] <= hold[s - 1];
		end
	end

	assign out.hold = hold[CLZ_STAGES - 1];
	assign out.shift = cnt[CLZ_STAGES - 1][0];

endmodule

// File: hdl/fpadd_normalize.sv
// Left normalization stage that shifts out leading zeros and corrects the exponent
`timescale 1ns/10ps

module fpadd_normalize (
	input  logic                 clk,
	input  fpadd_pkg::clz_out_t  in,
	output fpadd_pkg::norm_out_t out
);
	import fpadd_pkg::*;

	logic [31:0] shifted;

	assign shifted = in.hold.sum << in.shift;

	always_ff @(posedge clk) begin
		out.op <= in.hold.op;
		out.slow <= in.hold.slow;
		out.val.sign <= in.hold.sign;

		// Bit 31 is the implicit one after the shift
		{out.val.mant, out.guard, out.round} <= shifted[30:6];
		out.sticky <= in.hold.sticky | (|shifted[5:0]);

		// Carry position is the reference, hence the plus one
		{out.overflow, out.val.exp} <=
			{1'b0, in.hold.exp} - {3'b000, in.shift} + 9'd1;

		// Count of 32 means the sum is all zeros
		out.zero <= in.hold.zero | in.shift[5];
	end

endmodule

// File: hdl/fpadd_round.sv
// Nearest-even rounding, exponent step after rounding and special-result encoding
`timescale 1ns/10ps

module fpadd_round (
	input  logic                  clk,
	input  fpadd_pkg::round_in_t  in,
	output fpadd_pkg::float_t     q
);
	import fpadd_pkg::*;

	float_t r_val;
	logic r_slow;
	logic r_zero;
	logic r_step;

	float_t n_val;
	logic n_slow;
	logic n_zero;
	logic n_overflow;
	float_class_t n_class;

	always_ff @(posedge clk) begin
		r_val <= in.val;
		r_zero <= in.zero;
		r_slow <= in.slow | (in.overflow & ~in.zero);
		r_step <= 1'b0;

		// Ties go to the even mantissa
		if (in.guard && (in.round || in.sticky || in.val.mant[0]))
			{r_step, r_val.mant} <= {1'b0, in.val.mant} + 24'd1;
	end

	always_ff @(posedge clk) begin
		n_val <= r_val;
		n_slow <= r_slow;
		n_zero <= r_zero;
		n_overflow <= 1'b0;

		// Mantissa wrapped to zero, so 1.0 at the next exponent
		if (r_step)
			{n_overflow, n_val.exp} <= {1'b0, r_val.exp} + 9'd1;
	end

	assign n_class = classify_float(n_val);

	always_ff @(posedge clk) begin
		if (n_slow || n_overflow || is_special(n_class))
			q <= FLOAT_NAN;
		else if (n_zero)
			q <= '{sign: n_val.sign, exp: '0, mant: '0};
		else if (n_class.exp_zero)
			q <= FLOAT_NAN;
		else
			q <= n_val;
	end

endmodule

// File: hdl/fpadd_top.sv
// Top level of the pipelined float adder that chains the stages and delays the valid bit
`timescale 1ns/10ps

module fpadd_top #(
	parameter int CLZ_STAGES = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  fpadd_pkg::fp_op_e op,
	input  fpadd_pkg::float_t a,
	input  fpadd_pkg::float_t b,
	output logic              out_valid,
	output fpadd_pkg::float_t q
);
	import fpadd_pkg::*;

	// Align 3, add 1, count CLZ_STAGES, normalize 1, round 3
	localparam int LATENCY = 8 + CLZ_STAGES;

	addsub_in_t align_q;
	addsub_out_t add_q;
	clz_out_t clz_q;
	norm_out_t norm_q;
	logic [LATENCY-1:0] valid_pipe;

	fpadd_align align_i (
		.clk(clk),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.out(align_q)
	);

	fpadd_mant_add mant_add_i (
		.clk(clk),
		.in(align_q),
		.out(add_q)
	);

	fpadd_clz #(
		.CLZ_STAGES(CLZ_STAGES)
	) clz_i (
		.clk(clk),
		.in(add_q),
		.out(clz_q)
	);

	fpadd_normalize normalize_i (
		.clk(clk),
		.in(clz_q),
		.out(norm_q)
	);

	fpadd_round round_i (
		.clk(clk),
		.in(norm_q),
		.q(q)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[LATENCY-2:0], in_valid};
	end

	assign out_valid = valid_pipe[LATENCY-1];

endmodule

// File: verif/fpadd_tb.sv
// Testbench for the float adder that replays the data file vectors and checks q and latency
`timescale 1ns/10ps

module fpadd_tb;
	import fpadd_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int LATENCY = 12;
	localparam int RESET_CYCLES = 4;

	typedef struct packed {
		int     idx;
		int     launch;
		fp_op_e op;
		float_t q;
	} pend_t;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	fp_op_e op;
	float_t a;
	float_t b;
	logic out_valid;
	float_t q;

	// Four words per vector: op, a, b, expected q
	logic [31:0] vec_mem [0:4*MAX_VEC-1];
	int n_vec = 0;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	pend_t pending [$];

	fpadd_top #(
		.CLZ_STAGES(4)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.op(op),
		.a(a),
		.b(b),
		.out_valid(out_valid),
		.q(q)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic string op_name(fp_op_e o);
		case (o)
			OP_ADD:  return "float add";
			OP_SUB:  return "float subtract";
			default: return "int to float";
		endcase
	endfunction

	// Op words are small, so an address-tagged fill marks the end of the file
	function automatic logic [31:0] fill_word(int addr);
		return 32'hf000_0000 | addr;
	endfunction

	task automatic load_vectors();
		for (int i = 0; i < 4 * MAX_VEC; i++)
			vec_mem[i] = fill_word(i);
		$readmemh("verif/fpadd_input.dat", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[4 * n_vec] != fill_word(4 * n_vec))
			n_vec++;
	endtask

	task automatic drive_vector(int i);
		int gap;
		pend_t p;
		gap = $urandom_range(2, 0);
		repeat (gap) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
		@(negedge clk);
		in_valid = 1'b1;
		op = fp_op_e'(vec_mem[4 * i][1:0]);
		a = vec_mem[4 * i + 1];
		b = vec_mem[4 * i + 2];
		p.idx = i;
		p.launch = cyc;
		p.op = op;
		p.q = vec_mem[4 * i + 3];
		pending.push_back(p);
	endtask

	task automatic check_result(pend_t p);
		string name;
		name = $sformatf("%s vector %0d", op_name(p.op), p.idx);
		checks++;
		if (cyc - p.launch != LATENCY) begin
			$display("[FAIL] %s latency: expected %0d actual %0d",
				name, LATENCY, cyc - p.launch);
			errors++;
		end
		if (q !== p.q) begin
			$display("[FAIL] %s: expected %h actual %h", name, p.q, q);
			errors++;
		end
	endtask

	// Outputs settle after the rising edge and are sampled on the falling one
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			if (pending.size() == 0) begin
				$display("Unexpected out_valid at cycle %0d with nothing in flight", cyc);
				errors++;
			end else begin
				check_result(pending.pop_front());
			end
		end else if (out_valid !== 1'b0) begin
			$display("out_valid is unknown at cycle %0d", cyc);
			errors++;
		end else if (pending.size() != 0 && cyc - pending[0].launch >= LATENCY) begin
			$display("Missing out_valid for vector %0d", pending[0].idx);
			errors++;
			void'(pending.pop_front());
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		op = OP_ADD;
		a = '0;
		b = '0;
		void'($urandom(32'h556f));
		load_vectors();
		if (n_vec == 0) begin
			$display("No vectors could be read from the input file");
			errors++;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_vec; i++)
			drive_vector(i);
		@(negedge clk);
		in_valid = 1'b0;
		while (pending.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Worst case is about three cycles per vector plus reset and pipeline drain
	initial begin
		wait (n_vec > 0);
		#((n_vec * 4 + 100) * 4);
		$display("Watchdog timeout with results still outstanding");
		$display("Regression failed");
		$finish;
	end

endmodule

// File: verif/fpadd_input.dat
// Columns: op (0 add, 1 sub, 2 int to float), a, b, expected q; all hex
// b is ignored for int to float
// Normal addition with exact results
0 3f800000 3f800000 40000000
0 3fc00000 40100000 40700000
0 40a00000 c0400000 40000000
0 bfc00000 c0200000 c0800000
0 3f800000 00000001 3f800000
// Ties to even, down then up, and a rounding carry into the exponent
0 3f800000 33800000 3f800000
0 3f800001 33800000 3f800002
0 3fffffff 33800000 40000000
// Cancellation through the leading-zero path
1 3f800001 3f800000 34000000
1 3f800000 3f7fffff 33800000
1 40b00000 40a80000 3e800000
1 3f800000 40400000 c0000000
// Exact differences and signed zeros
1 3f800000 3f800000 00000000
1 c0000000 c0000000 00000000
0 80000000 80000000 80000000
0 80000000 00000000 00000000
// Integer to float
2 00000000 00000000 00000000
2 00000001 7f800000 3f800000
2 ffffffff 00000000 bf800000
2 7fffffff 00000000 4f000000
2 80000000 00000000 cf000000
2 000003e8 00000000 447a0000
2 fffffc18 00000000 c47a0000
// NaN and infinity inputs
0 7f800000 3f800000 7f800001
0 3f800000 7fc00000 7f800001
1 ff800000 7f800000 7f800001
// Exponent overflow in the sum and after rounding, then underflow
0 7f7fffff 7f7fffff 7f800001
0 7f7fffff 73000000 7f800001
1 00800001 00800000 7f800001

// File: build.f
hdl/fpadd_pkg.sv
hdl/fpadd_align.sv
hdl/fpadd_mant_add.sv
hdl/fpadd_clz.sv
hdl/fpadd_normalize.sv
hdl/fpadd_round.sv
hdl/fpadd_top.sv
verif/fpadd_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module fpadd_tb -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vfpadd_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" sim.log; then
	exit 0
fi
exit 1
